/* verification/sdram_stim.txt */
// columns: grp op bank row col wdata expected, all hex; op 1 write, 2 read, f end
// lines with the same grp are issued together, one per bank
00 1 0 0001 000 0123456789abcdef 0
01 2 0 0001 000 0 0123456789abcdef
02 1 0 0002 008 a5a5000011112222 0
03 2 0 0002 008 0 a5a5000011112222
04 2 0 0001 000 0 0123456789abcdef
05 1 0 0005 010 c0de0000feed0b00 0
05 1 1 0005 010 c0de1111feed0b01 0
05 1 2 0005 010 c0de2222feed0b02 0
05 1 3 0005 010 c0de3333feed0b03 0
06 2 0 0005 010 0 c0de0000feed0b00
06 2 1 0005 010 0 c0de1111feed0b01
06 2 2 0005 010 0 c0de2222feed0b02
06 2 3 0005 010 0 c0de3333feed0b03
07 2 1 0005 010 0 c0de1111feed0b01
08 2 1 0005 010 0 c0de1111feed0b01
09 f 0 0 0 0 0

/* compile.f */
source/sdram_pkg.sv
source/sdram_bank.sv
source/sdram_cmd_arbiter.sv
source/sdram_data_path.sv
source/sdram_ctrl.sv
verification/sdram_model.sv
verification/sdram_assert.sv
verification/sdram_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sdram_tb -f compile.f -o sim_sdram \
    && ./obj_dir/sim_sdram | tee /dev/stderr | grep -q "^All checks passed$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verification/sdram_tb.sv */
//////////////////////////////////////////////////////////////
// testbench for the four-bank SDRAM controller
// requests come from the stim file, groups share a start cycle
// reads are scored against expected data and return latency
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdram_tb;

    localparam int max_lines = 32;
    localparam int fields    = 7;   // grp op bank row col wdata expected
    localparam int rd_lat    = sdram_pkg::cas_lat + sdram_pkg::burst_len + 1;

    logic                  clk;
    logic                  rst;
    sdram_pkg::mem_req_t   req [sdram_pkg::num_banks];
    logic [3:0]            ack;
    logic                  rd_valid;
    logic [63:0]           rd_data;
    logic [1:0]            rd_bank;
    sdram_pkg::sdram_cmd_e cmd;
    logic [12:0]           sdram_a;
    logic [1:0]            ba;
    logic [15:0]           dq_out;
    logic                  dq_oe;
    logic [15:0]           dq_in;
    int                    proto_err;

    logic [63:0] stim [0:max_lines*fields-1];
    int          n_lines = 0;
    int          errors = 0;
    int          checks = 0;
    int          cyc = 0;                    // posedge count, monitor owned
    int          ack_cnt [4] = '{default: 0};
    logic [3:0]  pending = '0;               // request held per bank
    logic [3:0]  cur_rd = '0;
    int          cur_line [4];
    logic [1:0]  exp_bank_q [$];             // scoreboard, grant order
    logic [63:0] exp_data_q [$];
    int          exp_cyc_q [$];
    int          exp_line_q [$];

    sdram_ctrl dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .ack      (ack),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .rd_bank  (rd_bank),
        .cmd      (cmd),
        .sdram_a  (sdram_a),
        .ba       (ba),
        .dq_out   (dq_out),
        .dq_oe    (dq_oe),
        .dq_in    (dq_in)
    );

    sdram_model u_mem (
        .clk       (clk),
        .cmd       (cmd),
        .sdram_a   (sdram_a),
        .ba        (ba),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .dq_in     (dq_in),
        .proto_err (proto_err)
    );

    always #4 clk = ~clk;  // 8 ns period

    // issues one group of lines, holds each request until its ack
    task automatic run_group(input int first, output int next);
        int i;
        int b;
        int base [4];
        i = first;
        while (i < n_lines && stim[i*fields] == stim[first*fields]) begin
            b = int'(stim[i*fields+2][1:0]);
            req[b].rd    = (stim[i*fields+1] == 64'd2);
            req[b].wr    = (stim[i*fields+1] == 64'd1);
            req[b].row   = stim[i*fields+3][12:0];
            req[b].col   = stim[i*fields+4][8:0];
            req[b].wdata = stim[i*fields+5];
            base[b]      = ack_cnt[b];
            cur_line[b]  = i;
            cur_rd[b]    = req[b].rd;
            pending[b]   = 1'b1;
            i++;
        end
        next = i;
        while (pending != '0) begin
            @(negedge clk);
            for (b = 0; b < 4; b++) begin
                if (pending[b] && ack_cnt[b] != base[b]) begin
                    req[b]     = '0;         // drop the cycle after ack
                    pending[b] = 1'b0;
                end
            end
        end
    endtask

    // acks and read returns, sampled on the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            for (int b = 0; b < 4; b++) begin
                if (ack[b]) begin
                    checks++;
                    assert (pending[b]) else begin
                        errors++;
                        $display("ack on bank %0d with no request held, cycle %0d", b, cyc);
                    end
                    ack_cnt[b]++;
                    if (pending[b] && cur_rd[b]) begin
                        exp_bank_q.push_back(2'(b));
                        exp_data_q.push_back(stim[cur_line[b]*fields+6]);
                        exp_cyc_q.push_back(cyc + rd_lat);
                        exp_line_q.push_back(cur_line[b]);
                    end
                end
            end
            if (rd_valid) begin
                checks++;
                assert (exp_data_q.size() != 0) else begin
                    errors++;
                    $display("read data returned with no read outstanding, cycle %0d", cyc);
                end
                if (exp_data_q.size() != 0) begin
                    assert (rd_data == exp_data_q[0]) else begin
                        errors++;
                        $display("ERR line%0d_data exp %h got %h",
                                 exp_line_q[0], exp_data_q[0], rd_data);
                    end
                    assert (rd_bank == exp_bank_q[0]) else begin
                        errors++;
                        $display("ERR line%0d_bank exp %0d got %0d",
                                 exp_line_q[0], exp_bank_q[0], rd_bank);
                    end
                    assert (cyc == exp_cyc_q[0]) else begin
                        errors++;
                        $display("ERR line%0d_latency exp cycle %0d got %0d",
                                 exp_line_q[0], exp_cyc_q[0], cyc);
                    end
                    void'(exp_bank_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                    void'(exp_line_q.pop_front());
                end
            end
        end
        cyc++;
    end

    // watchdog, 200 cycles per stim line
    initial begin
        wait (n_lines > 0);
        repeat (200 * n_lines + 50) @(posedge clk);
        $display("timeout: requests or read data never completed");
        $display("Checks failed");
        $finish;
    end

    initial begin
        int idx;
        int nxt;
        int gap;
        clk = 1'b0;
        rst = 1'b1;
        for (int b = 0; b < 4; b++)
            req[b] = '0;
        void'($urandom(32'hc33f18ad));
        $readmemh("verification/sdram_stim.txt", stim);
        while (n_lines < max_lines && stim[n_lines*fields+1] != 64'hf)
            n_lines++;
        if (n_lines == 0) begin
            $display("stim file holds no accesses");
            $display("Checks failed");
            $finish;
        end else begin
            repeat (4) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;

            // quiet bus with nothing asked
            repeat (16) begin
                @(negedge clk);
                checks++;
                assert (cmd == sdram_pkg::cmd_nop && ack == '0 && !rd_valid) else begin
                    errors++;
                    $display("ERR idle exp cmd 7 ack 0 rd_valid 0 got cmd %h ack %b rd_valid %b",
                             cmd, ack, rd_valid);
                end
            end

            idx = 0;
            while (idx < n_lines) begin
                run_group(idx, nxt);
                idx = nxt;
                gap = int'($urandom_range(3, 0));
                repeat (gap) @(negedge clk);  // 0 keeps reads back to back
            end

            while (exp_data_q.size() != 0)
                @(negedge clk);
            repeat (12) @(negedge clk);   // room for any stray ack

            checks++;
            assert (proto_err == 0) else begin
                errors++;
                $display("SDRAM model saw %0d protocol violations", proto_err);
            end

            $display("summary: %0d lines, %0d checks, %0d errors", n_lines, checks, errors);
            if (errors == 0)
                $display("All checks passed");
            else
                $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verification/sdram_assert.sv */
//////////////////////////////////////////////////////////////
// concurrent checks on the SDRAM command pins
// bound into every sdram_ctrl instance
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdram_assert (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire sdram_pkg::sdram_cmd_e  cmd,
    input  wire logic                   dq_oe
);

    logic [2:0] rd_win;  // cycles left until the last read beat

    // read on the pins opens a window up to its fourth beat
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rd_win <= '0;
        else if (cmd == sdram_pkg::cmd_read)
            rd_win <= 3'(sdram_pkg::cas_lat + sdram_pkg::burst_len - 1);
        else if (rd_win != 3'd0)
            rd_win <= rd_win - 3'd1;
    end

    // pins idle while reset is held
    a_nop_in_reset: assert property (@(posedge clk) rst |-> cmd == sdram_pkg::cmd_nop)
        else $error("command on the pins during reset");

    // t_rrd of 2 -> no activate in the cycle after an activate
    a_rrd_gap: assert property (@(posedge clk) disable iff (rst)
        cmd == sdram_pkg::cmd_active |-> $past(cmd) != sdram_pkg::cmd_active)
        else $error("two activates closer than t_rrd");

    // no access while a read window or a write burst from before is running
    a_dq_free: assert property (@(posedge clk) disable iff (rst)
        (cmd == sdram_pkg::cmd_read || cmd == sdram_pkg::cmd_write)
            |-> rd_win == 3'd0 && !$past(dq_oe))
        else $error("read or write issued while the previous burst was still on DQ");

endmodule

bind sdram_ctrl sdram_assert u_assert (
    .clk   (clk),
    .rst   (rst),
    .cmd   (cmd),
    .dq_oe (dq_oe)
);

`default_nettype wire

/* verification/sdram_model.sv */
//////////////////////////////////////////////////////////////
// behavioral SDRAM for the controller testbench
// four banks, CAS 2, burst 4, sparse memory
// counts protocol errors, closed-row reads return 16'hdead
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire logic                   clk,
    input  wire sdram_pkg::sdram_cmd_e  cmd,
    input  wire logic [12:0]            sdram_a,
    input  wire logic [1:0]             ba,
    input  wire logic [15:0]            dq_out,
    input  wire logic                   dq_oe,
    output logic [15:0]                 dq_in,
    output int                          proto_err
);

    logic [15:0] mem [bit [23:0]];             // key is {bank, row, col}
    logic        bank_open [4] = '{default: 1'b0};
    logic [12:0] open_row [4];
    int          err_cnt = 0;
    int          rd_step = 0;                  // 1..4 -> beat being driven
    int          wr_step = 0;                  // 1..3 -> beat being taken
    logic [23:0] rd_key;
    logic [23:0] wr_key;
    logic        rd_ok;
    logic [15:0] dq_reg = '0;

    assign dq_in     = dq_reg;
    assign proto_err = err_cnt;

    // unwritten locations still read back something address dependent
    function automatic logic [15:0] fill(input logic [23:0] key);
        return key[15:0] ^ {key[23:16], key[7:0]};
    endfunction

    always @(posedge clk) begin
        if (dq_oe && wr_step == 0 && cmd != sdram_pkg::cmd_write)
            err_cnt++;                         // output enable with no beat due
        // beats of bursts already running
        if (wr_step != 0) begin
            if (!dq_oe)
                err_cnt++;                     // beat without output enable
            mem[wr_key + 24'(wr_step)] = dq_out;
            wr_step = (wr_step == 3) ? 0 : wr_step + 1;
        end
        if (rd_step != 0) begin
            if (!rd_ok)
                dq_reg <= 16'hdead;
            else if (mem.exists(rd_key + 24'(rd_step - 1)))
                dq_reg <= mem[rd_key + 24'(rd_step - 1)];
            else
                dq_reg <= fill(rd_key + 24'(rd_step - 1));
            rd_step = (rd_step == 4) ? 0 : rd_step + 1;
        end
        case (cmd)
            sdram_pkg::cmd_precharge: bank_open[ba] = 1'b0;
            sdram_pkg::cmd_active: begin
                if (bank_open[ba])
                    err_cnt++;                 // activate on an open bank
                bank_open[ba] = 1'b1;
                open_row[ba]  = sdram_a;
            end
            sdram_pkg::cmd_write: begin
                wr_key = {ba, open_row[ba], sdram_a[8:0]};
                if (!bank_open[ba] || !dq_oe) begin
                    err_cnt++;                 // write dropped
                end else begin
                    mem[wr_key] = dq_out;      // beat 0 sits with the command
                    wr_step = 1;
                end
            end
            sdram_pkg::cmd_read: begin
                rd_key  = {ba, open_row[ba], sdram_a[8:0]};
                rd_ok   = bank_open[ba];
                rd_step = 1;                   // first beat one cycle later
                if (!bank_open[ba])
                    err_cnt++;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/sdram_ctrl.sv */
//////////////////////////////////////////////////////////////
// top of the four-bank SDRAM command controller
// one request port per bank, shared command pins and DQ
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire sdram_pkg::mem_req_t           req [sdram_pkg::num_banks],
    output logic [sdram_pkg::num_banks-1:0]    ack,
    output logic                               rd_valid,
    output logic [sdram_pkg::word_w-1:0]       rd_data,
    output logic [1:0]                         rd_bank,
    output sdram_pkg::sdram_cmd_e              cmd,
    output logic [sdram_pkg::row_w-1:0]        sdram_a,
    output logic [1:0]                         ba,
    output logic [sdram_pkg::beat_w-1:0]       dq_out,
    output logic                               dq_oe,
    input  wire logic [sdram_pkg::beat_w-1:0]  dq_in
);

    logic [sdram_pkg::num_banks-1:0] br;
    logic [sdram_pkg::num_banks-1:0] bg;
    sdram_pkg::bank_cmd_t            bank_cmd [sdram_pkg::num_banks];
    logic [sdram_pkg::word_w-1:0]    wr_data [sdram_pkg::num_banks];
    logic                            dbusy;
    logic                            start;
    logic                            start_wr;
    logic [1:0]                      start_bank;

    for (genvar b = 0; b < sdram_pkg::num_banks; b++) begin : g_bank
        assign wr_data[b] = req[b].wdata;  // data path picks by start_bank

        sdram_bank u_bank (
            .clk      (clk),
            .rst      (rst),
            .req      (req[b]),
            .ack      (ack[b]),
            .br       (br[b]),
            .bank_cmd (bank_cmd[b]),
            .bg       (bg[b])
        );
    end

    sdram_cmd_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .br         (br),
        .bank_cmd   (bank_cmd),
        .bg         (bg),
        .dbusy      (dbusy),
        .start      (start),
        .start_wr   (start_wr),
        .start_bank (start_bank),
        .cmd        (cmd),
        .sdram_a    (sdram_a),
        .ba         (ba)
    );

    sdram_data_path u_data (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .start_wr   (start_wr),
        .start_bank (start_bank),
        .wr_data    (wr_data),
        .dbusy      (dbusy),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe),
        .dq_in      (dq_in),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .rd_bank    (rd_bank)
    );

endmodule

`default_nettype wire

/* source/sdram_data_path.sv */
//////////////////////////////////////////////////////////////
// DQ side of the controller
// drives write bursts out, follows read latency with a tag
// pipeline and packs four read beats into one tagged word
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdram_data_path (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         start,
    input  wire logic                         start_wr,
    input  wire logic [1:0]                   start_bank,
    input  wire logic [sdram_pkg::word_w-1:0] wr_data [sdram_pkg::num_banks],
    output logic                              dbusy,
    output logic [sdram_pkg::beat_w-1:0]      dq_out,
    output logic                              dq_oe,
    input  wire logic [sdram_pkg::beat_w-1:0] dq_in,
    output logic                              rd_valid,
    output logic [sdram_pkg::word_w-1:0]      rd_data,
    output logic [1:0]                        rd_bank
);

    localparam int lat = sdram_pkg::cas_lat;  // last tag stage index

    logic [2:0]                     busy_cnt;
    logic [2:0]                     wr_cnt;   // beats left to drive
    logic [sdram_pkg::word_w-1:0]   wr_shift;
    logic                           rd_vld [lat+1];
    logic [1:0]                     rd_tag [lat+1];
    logic                           cap_act;
    logic [1:0]                     beat_cnt;
    logic [1:0]                     cap_bank;
    logic [sdram_pkg::word_w-1:0]   asm_word;

    assign dbusy   = busy_cnt != '0;
    assign dq_oe   = wr_cnt != '0;  // lines up with the write on the pins
    assign dq_out  = wr_shift[sdram_pkg::beat_w-1:0];
    assign rd_data = asm_word;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_cnt <= '0;
            wr_cnt   <= '0;
            cap_act  <= 1'b0;
            beat_cnt <= '0;
            rd_valid <= 1'b0;
            for (int i = 0; i <= lat; i++)
                rd_vld[i] <= 1'b0;
        end else begin
            // hold off the next access until this burst has left DQ
            if (start)
                busy_cnt <= start_wr ? 3'(sdram_pkg::burst_len)
                                     : 3'(sdram_pkg::cas_lat + sdram_pkg::burst_len - 1);
            else if (busy_cnt != '0)
                busy_cnt <= busy_cnt - 3'd1;

            if (start && start_wr)
                wr_cnt <= 3'(sdram_pkg::burst_len);
            else if (wr_cnt != '0)
                wr_cnt <= wr_cnt - 3'd1;

            rd_vld[0] <= start && !start_wr;  // tail stage = first beat on dq_in
            for (int i = 1; i <= lat; i++)
                rd_vld[i] <= rd_vld[i-1];

            rd_valid <= 1'b0;
            if (rd_vld[lat]) begin
                cap_act  <= 1'b1;
                beat_cnt <= 2'd1;
            end else if (cap_act) begin
                beat_cnt <= beat_cnt + 2'd1;
                if (beat_cnt == 2'(sdram_pkg::burst_len - 1)) begin
                    cap_act  <= 1'b0;
                    rd_valid <= 1'b1;  // fourth beat just captured
                end
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (start && start_wr)
            wr_shift <= wr_data[start_bank];
        else if (dq_oe)
            wr_shift <= wr_shift >> sdram_pkg::beat_w;
        rd_tag[0] <= start_bank;
        for (int i = 1; i <= lat; i++)
            rd_tag[i] <= rd_tag[i-1];
        if (rd_vld[lat])
            cap_bank <= rd_tag[lat];
        if (rd_vld[lat] || cap_act)
            asm_word <= {dq_in, asm_word[sdram_pkg::word_w-1:sdram_pkg::beat_w]};
        if (cap_act && beat_cnt == 2'(sdram_pkg::burst_len - 1))
            rd_bank <= cap_bank;
    end

endmodule

`default_nettype wire

/* source/sdram_cmd_arbiter.sv */
//////////////////////////////////////////////////////////////
// command arbiter, one SDRAM command per cycle
// masks activates inside tRRD and accesses while DQ is busy,
// grants round robin and registers the winner onto the pins
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_arbiter (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [sdram_pkg::num_banks-1:0] br,
    input  wire sdram_pkg::bank_cmd_t          bank_cmd [sdram_pkg::num_banks],
    output logic [sdram_pkg::num_banks-1:0]    bg,
    input  wire logic                          dbusy,
    output logic                               start,
    output logic                               start_wr,
    output logic [1:0]                         start_bank,
    output sdram_pkg::sdram_cmd_e              cmd,
    output logic [sdram_pkg::row_w-1:0]        sdram_a,
    output logic [1:0]                         ba
);

    logic [sdram_pkg::num_banks-1:0] elig;
    logic [1:0]                      last;     // last granted bank
    logic [1:0]                      cand;
    logic [1:0]                      win;
    logic                            found;
    logic [1:0]                      rrd_cnt;  // nonzero -> no activate
    sdram_pkg::sdram_cmd_e           win_cmd;

    always_comb begin
        for (int b = 0; b < sdram_pkg::num_banks; b++) begin
            elig[b] = br[b];
            if (bank_cmd[b].cmd == sdram_pkg::cmd_active && rrd_cnt != '0)
                elig[b] = 1'b0;
            if ((bank_cmd[b].cmd == sdram_pkg::cmd_read ||
                 bank_cmd[b].cmd == sdram_pkg::cmd_write) && dbusy)
                elig[b] = 1'b0;  // DQ still reserved
        end
    end

    // search starts one past the last winner, wraps on 2 bits
    always_comb begin
        found = 1'b0;
        win   = last;
        cand  = last;
        for (int i = 1; i <= sdram_pkg::num_banks; i++) begin
            cand = last + 2'(i);
            if (!found && elig[cand]) begin
                found = 1'b1;
                win   = cand;
            end
        end
        bg = '0;
        if (found)
            bg[win] = 1'b1;
    end

    assign win_cmd    = bank_cmd[win].cmd;
    assign start      = found && (win_cmd == sdram_pkg::cmd_read ||
                                  win_cmd == sdram_pkg::cmd_write);
    assign start_wr   = found && (win_cmd == sdram_pkg::cmd_write);
    assign start_bank = win;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last    <= 2'(sdram_pkg::num_banks - 1);  // bank 0 first
            rrd_cnt <= '0;
            cmd     <= sdram_pkg::cmd_nop;
            sdram_a <= '0;
            ba      <= '0;
        end else begin
            cmd <= sdram_pkg::cmd_nop;
            if (found) begin
                last    <= win;
                cmd     <= win_cmd;  // pins lag the grant by one cycle
                sdram_a <= bank_cmd[win].addr;
                ba      <= win;
            end
            if (found && win_cmd == sdram_pkg::cmd_active)
                rrd_cnt <= 2'(sdram_pkg::t_rrd - 1);
            else if (rrd_cnt != '0)
                rrd_cnt <= rrd_cnt - 2'd1;
        end
    end

endmodule

`default_nettype wire

/* source/sdram_bank.sv */
//////////////////////////////////////////////////////////////
// bank engine, one per SDRAM bank
// tracks the open row and walks precharge / activate / access
// asking the arbiter for one command at a time through br
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdram_bank (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire sdram_pkg::mem_req_t  req,
    output logic                      ack,
    output logic                      br,
    output sdram_pkg::bank_cmd_t      bank_cmd,
    input  wire logic                 bg
);

    sdram_pkg::bank_state_e         state;  // registered phase
    sdram_pkg::bank_state_e         phase;  // what is asked this cycle
    logic                           row_open;
    logic [sdram_pkg::row_w-1:0]    open_row;
    logic [1:0]                     cnt;    // t_rp / t_rcd countdown
    logic                           req_any;
    logic                           row_hit;

    assign req_any = req.rd | req.wr;
    assign row_hit = row_open && (open_row == req.row);

    // idle decides straight away so a row hit costs no extra cycle
    always_comb begin
        phase = state;
        if (state == sdram_pkg::bank_idle && req_any) begin
            if (row_hit)
                phase = sdram_pkg::bank_access;
            else if (row_open)
                phase = sdram_pkg::bank_precharge;  // wrong row open
            else
                phase = sdram_pkg::bank_activate;
        end
    end

    // br only in phases whose own timers have run out
    assign br = (phase == sdram_pkg::bank_precharge) ||
                (phase == sdram_pkg::bank_activate)  ||
                (phase == sdram_pkg::bank_access);

    assign ack = bg && (phase == sdram_pkg::bank_access);

    always_comb begin
        bank_cmd.cmd  = sdram_pkg::cmd_nop;
        bank_cmd.addr = '0;  // A10 low -> precharge this bank only
        case (phase)
            sdram_pkg::bank_precharge: begin
                bank_cmd.cmd = sdram_pkg::cmd_precharge;
            end
            sdram_pkg::bank_activate: begin
                bank_cmd.cmd  = sdram_pkg::cmd_active;
                bank_cmd.addr = req.row;
            end
            sdram_pkg::bank_access: begin
                if (req.wr)
                    bank_cmd.cmd = sdram_pkg::cmd_write;
                else
                    bank_cmd.cmd = sdram_pkg::cmd_read;
                bank_cmd.addr = {{(sdram_pkg::row_w - sdram_pkg::col_w){1'b0}}, req.col};
            end
            default: ;
        endcase
    end

    // phase sequencing, only moves on a grant or a timer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= sdram_pkg::bank_idle;
            row_open <= 1'b0;
            cnt      <= '0;
        end else begin
            case (phase)
                sdram_pkg::bank_precharge: begin
                    if (bg) begin
                        state    <= sdram_pkg::bank_wait_rp;
                        row_open <= 1'b0;
                        cnt      <= 2'(sdram_pkg::t_rp - 1);
                    end
                end
                sdram_pkg::bank_wait_rp: begin
                    if (cnt == '0)
                        state <= sdram_pkg::bank_activate;
                    else
                        cnt <= cnt - 2'd1;
                end
                sdram_pkg::bank_activate: begin
                    if (bg) begin
                        state    <= sdram_pkg::bank_wait_rcd;
                        row_open <= 1'b1;
                        cnt      <= 2'(sdram_pkg::t_rcd - 1);
                    end
                end
                sdram_pkg::bank_wait_rcd: begin
                    if (cnt == '0)
                        state <= sdram_pkg::bank_access;
                    else
                        cnt <= cnt - 2'd1;
                end
                sdram_pkg::bank_access: begin
                    if (bg)
                        state <= sdram_pkg::bank_idle;  // row stays open
                end
                default: state <= sdram_pkg::bank_idle;
            endcase
        end
    end

    // row number only means something while row_open is set
    always_ff @(posedge clk) begin
        if (bg && phase == sdram_pkg::bank_activate)
            open_row <= req.row;
    end

endmodule

`default_nettype wire

/* source/sdram_pkg.sv */
//////////////////////////////////////////////////////////////
// shared definitions for the four-bank SDRAM controller
// widths, timing in clock cycles, pin command encodings and
// the request / bank command structs used by every module
//////////////////////////////////////////////////////////////
`default_nettype none

package sdram_pkg;

    localparam int num_banks = 4;   // one engine and one port per bank
    localparam int row_w     = 13;
    localparam int col_w     = 9;   // burst aligned by the user
    localparam int beat_w    = 16;  // DQ width
    localparam int word_w    = 64;  // one full burst
    localparam int burst_len = 4;   // beats per access

    // timing, all in clk cycles
    localparam int cas_lat   = 2;   // read command to first beat
    localparam int t_rp      = 2;   // precharge to activate, same bank
    localparam int t_rcd     = 2;   // activate to read/write, same bank
    localparam int t_rrd     = 2;   // activate to activate, any bank

    // pin encoding  /CS /RAS /CAS /WE
    typedef enum logic [3:0] {
        cmd_precharge = 4'b0010,
        cmd_active    = 4'b0011,
        cmd_write     = 4'b0100,
        cmd_read      = 4'b0101,
        cmd_nop       = 4'b0111
    } sdram_cmd_e;

    // phases of a bank engine
    typedef enum logic [2:0] {
        bank_idle,
        bank_precharge,
        bank_wait_rp,
        bank_activate,
        bank_wait_rcd,
        bank_access
    } bank_state_e;

    // user request, held until ack
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [row_w-1:0]  row;
        logic [col_w-1:0]  col;
        logic [word_w-1:0] wdata;  // beat 0 in the low bits
    } mem_req_t;

    // command a bank engine wants on the pins
    typedef struct packed {
        sdram_cmd_e       cmd;
        logic [row_w-1:0] addr;  // row, column or zero
    } bank_cmd_t;

endpackage

`default_nettype wire
